/* Makefile */
# Verilator flow for the paging core testbench

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f list.f --top-module tb_zx_mem

sim:
	verilator --binary --timing --assert -f list.f --top-module tb_zx_mem
	./obj_dir/Vtb_zx_mem | tee sim.log
	grep -qx "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* bus_front.sv */
// CPU-side handshake and address mapper; cpu_cycle must stay stable while cpu_req is high
`timescale 1ns/10ps
`include "zx_mem_cfg.svh"

module bus_front import zx_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  cpu_req,
	input  cpu_cycle_t            cpu_cycle,
	output logic                  cpu_ack,
	output logic [`ZX_DATA_W-1:0] cpu_rdata,
	input  page_state_t           pages,
	output logic                  io_wr,
	output logic                  ram_start,
	output ram_cmd_t              ram_cmd,
	input  logic                  ram_done,
	input  logic [`ZX_DATA_W-1:0] ram_rdata
);

	localparam logic [`ZX_BANK_W-1:0] rom_base    = `ZX_ROM_BASE;
	localparam logic [`ZX_BANK_W-1:0] bank_screen = `ZX_BANK_SCREEN2;
	localparam logic [`ZX_BANK_W-1:0] bank_mid    = `ZX_BANK_MID;

	typedef enum logic [1:0] {
		st_idle,
		st_issue,     // Strobes go out
		st_wait,      // RAM access or one settle cycle
		st_ack
	} state_e;

	state_e                state;
	cpu_cycle_t            cyc_q;
	logic                  skip_q;
	logic [`ZX_DATA_W-1:0] rdata_q;

	logic [1:0]            slot;
	logic                  special;
	logic [1:0]            rom_num;
	logic [`ZX_BANK_W-1:0] bank;
	logic                  rom_write;

	// +3 all-RAM layouts, selected by 1FFD bits 2:1
	function automatic logic [2:0] special_bank(input logic [1:0] sel, input logic [1:0] s);
		logic [2:0] b;
		case (sel)
			2'd0:    b = {1'b0, s};                              // 0 1 2 3
			2'd1:    b = {1'b1, s};                              // 4 5 6 7
			2'd2:    b = (s == 2'd3) ? 3'd3 : {1'b1, s};         // 4 5 6 3
			default: b = (s == 2'd3) ? 3'd3 : (s == 2'd1) ? 3'd7 : {1'b1, s};
		endcase
		return b;
	endfunction

	// ==========================================================================
	// Address mapping
	// ==========================================================================
	always_comb begin
		slot    = cyc_q.addr[`ZX_ADDR_W-1 -: 2];
		special = (pages.model == model_plus3) && pages.reg_1ffd[0];
		case (pages.model)
			model_48:    rom_num = 2'd3;
			model_plus3: rom_num = {pages.reg_1ffd[2], pages.reg_7ffd[4]};
			default:     rom_num = {1'b0, pages.reg_7ffd[4]};
		endcase
		if (special) begin
			bank = {{(`ZX_BANK_W-3){1'b0}}, special_bank(pages.reg_1ffd[2:1], slot)};
		end else begin
			case (slot)
				2'd0:    bank = rom_base + {{(`ZX_BANK_W-2){1'b0}}, rom_num};
				2'd1:    bank = bank_screen;
				2'd2:    bank = bank_mid;
				default: bank = (pages.model == model_48) ? '0 :
				                {{(`ZX_BANK_W-3){1'b0}}, pages.reg_7ffd[2:0]};
			endcase
		end
		rom_write = !special && (slot == 2'd0) && cyc_q.wr;   // Silently dropped
	end

	assign ram_cmd.addr  = {bank, cyc_q.addr[`ZX_OFS_W-1:0]};
	assign ram_cmd.wdata = cyc_q.wdata;
	assign ram_cmd.wr    = cyc_q.wr;

	// ==========================================================================
	// Cycle FSM
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle:  if (cpu_req) state <= st_issue;
				st_issue: state <= st_wait;
				st_wait:  if (skip_q || ram_done) state <= st_ack;
				st_ack:   if (!cpu_req) state <= st_idle;
				default:  state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (state == st_idle && cpu_req)
			cyc_q <= cpu_cycle;
		if (state == st_issue) begin
			skip_q  <= cyc_q.io | rom_write;
			rdata_q <= '1;                // I/O reads float high
		end
		if (state == st_wait && !skip_q && ram_done)
			rdata_q <= ram_rdata;
	end

	assign io_wr     = (state == st_issue) & cyc_q.io & cyc_q.wr;
	assign ram_start = (state == st_issue) & ~cyc_q.io & ~rom_write;
	assign cpu_ack   = (state == st_ack);
	assign cpu_rdata = rdata_q;

	// Req level at the edge where ack went high
	a_ack_with_req: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(cpu_ack) |-> $past(cpu_req))
		else $error("bus_front: cpu_ack rose after the host dropped cpu_req");

	a_done_expected: assert property (@(posedge clk_sys) disable iff (reset)
		ram_done |-> state == st_wait && !skip_q)
		else $error("bus_front: RAM done with no access outstanding");

endmodule

/* list.f */
+incdir+.
zx_mem_pkg.sv
page_regs.sv
ram_cycle.sv
bus_front.sv
zx_mem_map.sv
tb_checker.sv
tb_zx_mem.sv

/* page_regs.sv */
// Paging and ULA registers; writes only, model must be stable while reset is high
`timescale 1ns/10ps
`include "zx_mem_cfg.svh"

module page_regs import zx_mem_pkg::*; (
	input  logic        clk_sys,
	input  logic        reset,
	input  zx_model_e   model,
	input  logic        io_wr,      // One-cycle I/O write strobe
	input  cpu_cycle_t  cycle,
	output page_state_t pages,
	output ula_port_t   ula
);

	localparam logic [`ZX_ADDR_W-1:0] port_7ffd = `ZX_PORT_7FFD;
	localparam logic [`ZX_ADDR_W-1:0] port_1ffd = `ZX_PORT_1FFD;
	localparam logic [`ZX_ADDR_W-1:0] port_fe   = `ZX_PORT_FE;

	zx_model_e             model_q;
	logic [`ZX_DATA_W-1:0] reg_7ffd;
	logic [`ZX_DATA_W-1:0] reg_1ffd;
	ula_port_t             ula_q;

	logic                  is_plus3;
	logic                  lock;
	logic                  sel_7ffd;
	logic                  sel_1ffd;
	logic                  sel_fe;

	// ==========================================================================
	// Port decode
	// ==========================================================================
	assign is_plus3 = (model_q == model_plus3);
	assign lock     = (model_q == model_48) | reg_7ffd[5];   // 48K never pages

	// 7FFD: A15 and A1 low, A14 only decoded on +3
	assign sel_7ffd = (cycle.addr[15] == port_7ffd[15]) &
	                  (cycle.addr[1] == port_7ffd[1]) &
	                  (cycle.addr[14] | ~is_plus3);

	assign sel_1ffd = is_plus3 &
	                  (cycle.addr[15:12] == port_1ffd[15:12]) &
	                  (cycle.addr[1] == port_1ffd[1]);

	assign sel_fe   = (cycle.addr[0] == port_fe[0]);    // Any even port

	// ==========================================================================
	// Registers
	// ==========================================================================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			model_q  <= model;     // Sampled for as long as reset is held
			reg_7ffd <= '0;
			reg_1ffd <= '0;
		end else if (io_wr && !lock) begin
			if (sel_7ffd)
				reg_7ffd <= cycle.wdata;
			if (sel_1ffd)
				reg_1ffd <= cycle.wdata;
		end
	end

	// Border, mic and ear
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula_q <= '0;
		end else if (io_wr && sel_fe) begin
			ula_q.border <= cycle.wdata[2:0];
			ula_q.mic    <= cycle.wdata[3];
			ula_q.ear    <= cycle.wdata[4];
		end
	end

	assign pages.reg_7ffd = reg_7ffd;
	assign pages.reg_1ffd = reg_1ffd;
	assign pages.model    = model_q;
	assign ula            = ula_q;

	// 1FFD belongs to the +3 alone, whatever the bus does
	a_1ffd_plus3_only: assert property (@(posedge clk_sys) disable iff (reset)
		!is_plus3 |-> reg_1ffd == '0)
		else $error("page_regs: 1FFD changed on a non +3 model");

endmodule

/* ram_cycle.sv */
// Four-phase requester to the external RAM; one access at a time, start only when idle
`timescale 1ns/10ps
`include "zx_mem_cfg.svh"

module ram_cycle import zx_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  logic                  start,
	input  ram_cmd_t              cmd,
	output logic                  done,       // One-cycle pulse, rdata valid
	output logic [`ZX_DATA_W-1:0] rdata,
	output logic                  ram_req,
	output ram_cmd_t              ram_cmd,
	input  logic                  ram_ack,
	input  logic [`ZX_DATA_W-1:0] ram_rdata
);

	typedef enum logic [1:0] {
		st_idle,
		st_req,       // req high, waiting for ack
		st_release    // req low, waiting for ack to drop
	} state_e;

	state_e                state;
	ram_cmd_t              cmd_q;
	logic [`ZX_DATA_W-1:0] rdata_q;
	logic                  done_q;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state  <= st_idle;
			done_q <= 1'b0;
		end else begin
			done_q <= 1'b0;
			case (state)
				st_idle:
					if (start)
						state <= st_req;
				st_req:
					if (ram_ack)
						state <= st_release;
				st_release:
					if (!ram_ack) begin
						state  <= st_idle;
						done_q <= 1'b1;
					end
				default:
					state <= st_idle;
			endcase
		end
	end

	// Payload
	always_ff @(posedge clk_sys) begin
		if (state == st_idle && start)
			cmd_q <= cmd;
		if (state == st_req && ram_ack)
			rdata_q <= ram_rdata;     // Valid as ack rises
	end

	assign ram_req = (state == st_req);
	assign ram_cmd = cmd_q;
	assign done    = done_q;
	assign rdata   = rdata_q;

	a_start_idle: assert property (@(posedge clk_sys) disable iff (reset)
		start |-> state == st_idle)
		else $error("ram_cycle: start while an access is in flight");

	// Ack level at the edge where req went high
	a_req_after_ack: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(ram_req) |-> !$past(ram_ack))
		else $error("ram_cycle: ram_req rose with ram_ack still high");

endmodule

/* tb_checker.sv */
// Checks the DUT from its ports alone; assumes one CPU cycle in flight and the RAM fill of tb_zx_mem
`timescale 1ns/10ps
`include "zx_mem_cfg.svh"

module tb_checker import zx_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_model_e             model,
	input  logic                  cpu_req,
	input  cpu_cycle_t            cpu_cycle,
	input  logic                  cpu_ack,
	input  logic [`ZX_DATA_W-1:0] cpu_rdata,
	input  logic                  ram_req,
	input  ram_cmd_t              ram_cmd,
	input  logic                  ram_ack,
	input  ula_port_t             ula,
	input  logic                  report,     // Rising edge prints the summary
	output int                    errors
);

	logic [7:0]            mem_written [logic [`ZX_PHYS_W-1:0]];   // Bytes written so far
	zx_model_e             m_model;
	logic [7:0]            m_7ffd;
	logic [7:0]            m_1ffd;
	ula_port_t             m_ula;
	cpu_cycle_t            cur;
	logic [`ZX_PHYS_W-1:0] exp_addr;
	logic                  expect_ram;
	logic                  busy = 1'b0;
	int                    ram_seen = 0;
	int                    error_count = 0;
	int                    check_count = 0;
	logic                  reset_q = 1'b1;
	logic                  cpu_req_q = 1'b0;
	logic                  cpu_ack_q = 1'b0;
	logic                  ram_req_q = 1'b0;
	logic                  ram_ack_q = 1'b0;

	assign errors = error_count;

	// ==========================================================================
	// Reference model
	// ==========================================================================
	function automatic logic [7:0] pattern_byte(input logic [`ZX_PHYS_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]};
	endfunction

	function automatic logic [7:0] expected_byte(input logic [`ZX_PHYS_W-1:0] a);
		return mem_written.exists(a) ? mem_written[a] : pattern_byte(a);
	endfunction

	function automatic logic special_mode();
		return (m_model == model_plus3) && m_1ffd[0];
	endfunction

	// Slot to bank, then bank and offset to a physical address
	function automatic logic [`ZX_PHYS_W-1:0] map_phys(input logic [15:0] a);
		logic [15:0] layout;
		logic [1:0]  rom;
		logic [5:0]  bank;
		int          s;
		s = int'(a[15:14]);
		if (special_mode()) begin
			case (m_1ffd[2:1])
				2'd0:    layout = 16'h0123;   // One nibble per slot, slot 0 first
				2'd1:    layout = 16'h4567;
				2'd2:    layout = 16'h4563;
				default: layout = 16'h4763;
			endcase
			bank = {2'b00, layout[12 - 4*s +: 4]};
		end else begin
			if (m_model == model_48)
				rom = 2'd3;
			else if (m_model == model_128)
				rom = {1'b0, m_7ffd[4]};
			else
				rom = {m_1ffd[2], m_7ffd[4]};
			case (s)
				0:       bank = 6'(`ZX_ROM_BASE) + {4'b0000, rom};
				1:       bank = 6'd5;
				2:       bank = 6'd2;
				default: bank = (m_model == model_48) ? 6'd0 : {3'b000, m_7ffd[2:0]};
			endcase
		end
		return {bank, a[13:0]};
	endfunction

	function automatic void apply_io_write(input cpu_cycle_t c);
		logic locked;
		locked = (m_model == model_48) || m_7ffd[5];     // Value before this write
		if (!locked && !c.addr[15] && !c.addr[1] && (c.addr[14] || m_model != model_plus3))
			m_7ffd = c.wdata;
		if (!locked && m_model == model_plus3 && c.addr[15:12] == 4'b0001 && !c.addr[1])
			m_1ffd = c.wdata;
		if (!c.addr[0]) begin
			m_ula.border = c.wdata[2:0];
			m_ula.mic    = c.wdata[3];
			m_ula.ear    = c.wdata[4];
		end
	endfunction

	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		check_count++;
		if (got !== exp) begin
			error_count++;
			$display("error: %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_fault(input string msg);
		error_count++;
		$display("%s at %0t", msg, $time);
	endtask

	// ==========================================================================
	// Port watcher
	// ==========================================================================
	always @(posedge clk_sys) begin
		if (reset) begin
			m_model = model;
			m_7ffd  = '0;
			m_1ffd  = '0;
			m_ula   = '0;
			busy    = 1'b0;
		end else begin
			if (reset_q) begin     // First edge out of reset
				check_value("cpu_ack", 32'(cpu_ack), 32'(1'b0));
				check_value("ram_req", 32'(ram_req), 32'(1'b0));
				check_value("ula", 32'(ula), 32'(0));
			end
			// DUT outputs change on the edge, host and RAM inputs 10 ns later
			if (cpu_ack && !cpu_ack_q && !cpu_req_q)
				report_fault("Handshake fault, cpu_ack rose while cpu_req was low");
			if (cpu_req && !cpu_req_q && cpu_ack)
				report_fault("Handshake fault, cpu_req rose while cpu_ack was high");
			if (ram_ack && !ram_ack_q && !ram_req)
				report_fault("Handshake fault, ram_ack rose while ram_req was low");
			if (ram_req && !ram_req_q && ram_ack_q)
				report_fault("Handshake fault, ram_req rose while ram_ack was high");

			if (ram_req && !ram_req_q) begin
				if (!busy || !expect_ram || ram_seen != 0) begin
					report_fault("RAM request without a mapped CPU access outstanding");
				end else begin
					check_value("ram_cmd.addr", 32'(ram_cmd.addr), 32'(exp_addr));
					check_value("ram_cmd.wr", 32'(ram_cmd.wr), 32'(cur.wr));
					if (cur.wr) begin
						check_value("ram_cmd.wdata", 32'(ram_cmd.wdata), 32'(cur.wdata));
						mem_written[exp_addr] = cur.wdata;
					end
				end
				ram_seen++;
			end

			if (cpu_ack && !cpu_ack_q) begin
				if (!busy) begin
					report_fault("cpu_ack rose with no CPU cycle accepted");
				end else begin
					busy = 1'b0;
					if (expect_ram && ram_seen == 0)
						report_fault("Memory cycle completed without a RAM access");
					if (cur.io && cur.wr) begin
						apply_io_write(cur);
						check_value("ula", 32'(ula), 32'(m_ula));
					end else if (cur.io) begin
						check_value("cpu_rdata", 32'(cpu_rdata), 32'(8'hFF));
					end else if (!cur.wr) begin
						check_value("cpu_rdata", 32'(cpu_rdata), 32'(expected_byte(exp_addr)));
					end
				end
			end

			if (!busy && cpu_req && !cpu_ack) begin   // DUT accepts on this edge
				busy       = 1'b1;
				cur        = cpu_cycle;
				exp_addr   = map_phys(cpu_cycle.addr);
				expect_ram = !cpu_cycle.io &&
				             !(!special_mode() && cpu_cycle.addr[15:14] == 2'd0 && cpu_cycle.wr);
				ram_seen   = 0;
			end
		end
		reset_q   = reset;
		cpu_req_q = cpu_req;
		cpu_ack_q = cpu_ack;
		ram_req_q = ram_req;
		ram_ack_q = ram_ack;
	end

	always @(posedge report)
		$display("Checker summary: %0d checks, %0d errors", check_count, error_count);

endmodule

/* tb_zx_mem.sv */
// Random CPU traffic on the 48K, 128K and +3 models; seed 53, 400 cycles per model, 1 MB RAM model
`timescale 1ns/10ps
`include "zx_mem_cfg.svh"

module tb_zx_mem import zx_mem_pkg::*; ();

	localparam int n_phases     = 3;
	localparam int n_ops        = 400;
	localparam int reset_cycles = 10;
	localparam int cycle_limit  = n_phases * (n_ops * 20 + reset_cycles + 2);
	localparam int ram_size     = 1 << `ZX_PHYS_W;

	logic                  clk_sys;
	logic                  reset;
	zx_model_e             model;
	logic                  cpu_req;
	cpu_cycle_t            cpu_cycle;
	logic                  cpu_ack;
	logic [`ZX_DATA_W-1:0] cpu_rdata;
	logic                  ram_req;
	ram_cmd_t              ram_cmd;
	logic                  ram_ack;
	logic [`ZX_DATA_W-1:0] ram_rdata;
	ula_port_t             ula;
	logic                  report;
	int                    errors;
	int                    cycle_count = 0;
	logic [`ZX_DATA_W-1:0] ram_mem [0:ram_size-1];

	zx_mem_map i_dut (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.model     (model),
		.cpu_req   (cpu_req),
		.cpu_cycle (cpu_cycle),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.ram_req   (ram_req),
		.ram_cmd   (ram_cmd),
		.ram_ack   (ram_ack),
		.ram_rdata (ram_rdata),
		.ula       (ula)
	);

	tb_checker i_checker (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.model     (model),
		.cpu_req   (cpu_req),
		.cpu_cycle (cpu_cycle),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.ram_req   (ram_req),
		.ram_cmd   (ram_cmd),
		.ram_ack   (ram_ack),
		.ula       (ula),
		.report    (report),
		.errors    (errors)
	);

	initial begin
		clk_sys = 1'b0;
		forever #50 clk_sys = ~clk_sys;
	end

	always @(posedge clk_sys) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout, the run did not finish within %0d clock cycles", cycle_limit);
			$display("Checks failed");
			$finish;
		end
	end

	function automatic logic [7:0] pattern_byte(input logic [`ZX_PHYS_W-1:0] a);
		return a[7:0] ^ a[15:8] ^ {a[19:16], a[19:16]};
	endfunction

	// ==========================================================================
	// Stimulus
	// ==========================================================================
	function automatic cpu_cycle_t random_cycle();
		cpu_cycle_t c;
		c.io    = ($urandom_range(2, 0) == 0);
		c.wdata = 8'($urandom);
		if (c.io) begin
			c.wr = ($urandom_range(3, 0) != 0);
			case ($urandom_range(7, 0))
				0, 1:    c.addr = {8'($urandom), 8'hFE};   // Any even port
				2:       c.addr = `ZX_PORT_7FFD;
				3:       c.addr = `ZX_PORT_1FFD;
				4:       c.addr = 16'h7FFF;                // A1 high
				5:       c.addr = 16'hFFFD;                // A15 high
				6:       c.addr = ($urandom_range(1, 0) != 0) ? 16'h3FFD : 16'h0FFD;
				default: c.addr = 16'($urandom);
			endcase
			if ($urandom_range(15, 0) != 0)
				c.wdata[5] = 1'b0;     // Keep the lock rare
		end else begin
			c.wr = ($urandom_range(1, 0) != 0);
			c.addr[15:14] = 2'($urandom);
			// Small offsets so reads often hit earlier writes
			c.addr[13:0] = ($urandom_range(3, 0) != 0) ? 14'($urandom_range(31, 0)) :
			               14'($urandom);
		end
		return c;
	endfunction

	// Full four-phase cycle, entered and left 10 ns after a rising edge
	task automatic bus_cycle(input cpu_cycle_t c);
		cpu_cycle = c;
		cpu_req   = 1'b1;
		do begin
			@(posedge clk_sys);
			#10;
		end while (!cpu_ack);
		cpu_req = 1'b0;
		do begin
			@(posedge clk_sys);
			#10;
		end while (cpu_ack);
	endtask

	task automatic run_phase(input zx_model_e mdl);
		cpu_cycle_t c;
		@(posedge clk_sys);
		#10;
		reset = 1'b1;
		model = mdl;      // Latched by the DUT during reset
		repeat (reset_cycles) @(posedge clk_sys);
		#10;
		reset = 1'b0;
		for (int i = 0; i < n_ops; i++) begin
			c = random_cycle();
			bus_cycle(c);
		end
	endtask

	// ==========================================================================
	// RAM responder, 0 to 4 cycles before ack
	// ==========================================================================
	initial begin : ram_responder
		int wait_cycles;
		ram_ack   = 1'b0;
		ram_rdata = '0;
		for (int a = 0; a < ram_size; a++)
			ram_mem[a] = pattern_byte(20'(a));
		forever begin
			@(posedge clk_sys);
			#10;
			if (ram_req) begin
				wait_cycles = $urandom_range(4, 0);
				repeat (wait_cycles) begin
					@(posedge clk_sys);
					#10;
				end
				if (ram_cmd.wr)
					ram_mem[ram_cmd.addr] = ram_cmd.wdata;
				else
					ram_rdata = ram_mem[ram_cmd.addr];
				ram_ack = 1'b1;
				do begin
					@(posedge clk_sys);
					#10;
				end while (ram_req);
				ram_ack = 1'b0;
			end
		end
	end

	initial begin
		reset     = 1'b1;
		model     = model_48;
		cpu_req   = 1'b0;
		cpu_cycle = '0;
		report    = 1'b0;
		void'($urandom(53));
		run_phase(model_48);
		run_phase(model_128);
		run_phase(model_plus3);
		repeat (2) @(posedge clk_sys);
		report = 1'b1;
		#1;
		if (errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* zx_mem_cfg.svh */
// Widths and the port and bank map of the paging core; ROM n lives in bank ZX_ROM_BASE + n
`ifndef ZX_MEM_CFG_SVH
`define ZX_MEM_CFG_SVH

// ==========================================================================
// Bus widths
// ==========================================================================
`define ZX_ADDR_W        16     // Z80 address bus
`define ZX_PHYS_W        20     // 1 MB external RAM
`define ZX_BANK_W        6      // 16K banks
`define ZX_OFS_W         14     // Offset inside one bank
`define ZX_DATA_W        8

// ==========================================================================
// I/O ports, full addresses
// Decode is partial; only some bits of these take part
// ==========================================================================
`define ZX_PORT_7FFD     16'h7FFD
`define ZX_PORT_1FFD     16'h1FFD
`define ZX_PORT_FE       16'h00FE

// ==========================================================================
// Fixed banks
// ==========================================================================
`define ZX_ROM_BASE      8      // ROM 0, up to four ROMs follow
`define ZX_BANK_SCREEN2  5      // Slot 1 in normal mode
`define ZX_BANK_MID      2      // Slot 2 in normal mode

`endif

/* zx_mem_map.sv */
// Paging core top; model is sampled during reset, one CPU cycle in flight at a time
`timescale 1ns/10ps
`include "zx_mem_cfg.svh"

module zx_mem_map import zx_mem_pkg::*; (
	input  logic                  clk_sys,
	input  logic                  reset,
	input  zx_model_e             model,
	// CPU side
	input  logic                  cpu_req,
	input  cpu_cycle_t            cpu_cycle,
	output logic                  cpu_ack,
	output logic [`ZX_DATA_W-1:0] cpu_rdata,
	// RAM side
	output logic                  ram_req,
	output ram_cmd_t              ram_cmd,
	input  logic                  ram_ack,
	input  logic [`ZX_DATA_W-1:0] ram_rdata,
	output ula_port_t             ula
);

	page_state_t           pages;
	logic                  io_wr;
	logic                  ram_start;
	ram_cmd_t              mapped_cmd;
	logic                  ram_done;
	logic [`ZX_DATA_W-1:0] ram_rd_data;

	page_regs i_page_regs (
		.clk_sys (clk_sys),
		.reset   (reset),
		.model   (model),
		.io_wr   (io_wr),
		.cycle   (cpu_cycle),     // Held by the host until ack
		.pages   (pages),
		.ula     (ula)
	);

	ram_cycle i_ram_cycle (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.start     (ram_start),
		.cmd       (mapped_cmd),
		.done      (ram_done),
		.rdata     (ram_rd_data),
		.ram_req   (ram_req),
		.ram_cmd   (ram_cmd),
		.ram_ack   (ram_ack),
		.ram_rdata (ram_rdata)
	);

	bus_front i_bus_front (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.cpu_req   (cpu_req),
		.cpu_cycle (cpu_cycle),
		.cpu_ack   (cpu_ack),
		.cpu_rdata (cpu_rdata),
		.pages     (pages),
		.io_wr     (io_wr),
		.ram_start (ram_start),
		.ram_cmd   (mapped_cmd),
		.ram_done  (ram_done),
		.ram_rdata (ram_rd_data)
	);

endmodule

/* zx_mem_pkg.sv */
// Shared types of the paging core; field order inside each struct is part of the bus encoding
package zx_mem_pkg;

`include "zx_mem_cfg.svh"

	// Machine model, latched at reset
	typedef enum logic [1:0] {
		model_48    = 2'd0,
		model_128   = 2'd1,
		model_plus3 = 2'd2
	} zx_model_e;

	// One CPU bus cycle as presented by the host
	typedef struct packed {
		logic [`ZX_ADDR_W-1:0] addr;
		logic [`ZX_DATA_W-1:0] wdata;
		logic                  wr;      // 1 = write, 0 = read
		logic                  io;      // 1 = I/O, 0 = memory
	} cpu_cycle_t;

	// Paging state seen by the address mapper
	typedef struct packed {
		logic [`ZX_DATA_W-1:0] reg_7ffd;   // 2:0 RAM page, 4 ROM low, 5 lock
		logic [`ZX_DATA_W-1:0] reg_1ffd;   // 0 special, 2:1 ROM high / special sel
		zx_model_e             model;
	} page_state_t;

	// ULA output latch at port FE
	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_port_t;

	// One access on the external RAM
	typedef struct packed {
		logic [`ZX_PHYS_W-1:0] addr;
		logic [`ZX_DATA_W-1:0] wdata;
		logic                  wr;
	} ram_cmd_t;

	// 26 + 18 + 5 + 29 bits on the wires between blocks
	localparam int cpu_cycle_w  = $bits(cpu_cycle_t);
	localparam int page_state_w = $bits(page_state_t);
	localparam int ula_port_w   = $bits(ula_port_t);
	localparam int ram_cmd_w    = $bits(ram_cmd_t);

endpackage
